/* hw/rgbw_pkg.sv */
`default_nettype none

package rgbw_pkg;

    // spi bytes, colour values and duties
    typedef logic [7:0] byte_t;
    // full multiplier product
    typedef logic [15:0] prod_t;

    // bytes in a valid frame
    localparam int FRAME_LEN = 7;
    // byte counter width, room for one past FRAME_LEN
    localparam int BCNT_W = 4;

    // field offsets within the frame
    localparam int IDX_MODE  = 0;
    localparam int IDX_LINT  = 1;
    localparam int IDX_CIDX  = 2;
    localparam int IDX_RED   = 3;
    localparam int IDX_GREEN = 4;
    localparam int IDX_BLUE  = 5;
    localparam int IDX_WHITE = 6;

    // mode byte, anything else turns all channels off
    typedef enum logic [7:0] {
        MODE_DIRECT  = 8'd0,
        MODE_PALETTE = 8'd1
    } mode_e;

    // fixed colours, red green blue white per entry
    localparam byte_t PALETTE [8][4] = '{
        '{8'hFF, 8'h00, 8'h00, 8'h00},
        '{8'h00, 8'hFF, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'hFF, 8'h00},
        '{8'h00, 8'h00, 8'h00, 8'hFF},
        '{8'hFF, 8'hFF, 8'h00, 8'h00},
        '{8'h00, 8'hFF, 8'hFF, 8'h00},
        '{8'hFF, 8'h00, 8'hFF, 8'h00},
        '{8'hFF, 8'h80, 8'h20, 8'h40}
    };

    // one pwm step every PWM_DIV clocks
    localparam int PWM_DIV   = 4;
    localparam int PWM_PRE_W = $clog2(PWM_DIV);

    // colour scaler fsm
    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT,
        S_STORE
    } scale_state_e;

endpackage

`default_nettype wire

/* hw/spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave import rgbw_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sck,
    input  logic  cs,
    input  logic  mosi,
    output byte_t byte_data,
    output logic  byte_rdy,
    output logic  frame_end
);

    // two sync stages plus one history stage for edges
    logic [2:0] sck_ff;
    logic [2:0] cs_ff;
    logic [1:0] mosi_ff;
    logic [2:0] bit_cnt;
    logic [6:0] shreg;
    logic       sck_rise;
    logic       cs_rise;
    logic       cs_s;
    logic       mosi_s;

    assign cs_s     = cs_ff[1];
    assign mosi_s   = mosi_ff[1];
    assign sck_rise = sck_ff[1] & ~sck_ff[2];
    assign cs_rise  = cs_ff[1] & ~cs_ff[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_ff    <= '0;
            // cs idles high, so no false frame end after reset
            cs_ff     <= '1;
            mosi_ff   <= '0;
            bit_cnt   <= '0;
            byte_rdy  <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            sck_ff    <= {sck_ff[1:0], sck};
            cs_ff     <= {cs_ff[1:0], cs};
            mosi_ff   <= {mosi_ff[0], mosi};
            byte_rdy  <= 1'b0;
            frame_end <= cs_rise;
            if (cs_s) begin
                // deselected, restart byte alignment
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                // eighth bit completes the byte
                if (bit_cnt == 3'd7) begin
                    byte_rdy <= 1'b1;
                end
            end
        end
    end

    // msb first shift, byte latched on the last bit
    always_ff @(posedge clk) begin
        if (!cs_s && sck_rise) begin
            shreg <= {shreg[5:0], mosi_s};
            if (bit_cnt == 3'd7) begin
                byte_data <= {shreg, mosi_s};
            end
        end
    end

    // host keeps cs low well past the last sck edge
    a_rdy_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        byte_rdy |-> !cs_s);

endmodule

`default_nettype wire

/* hw/frame_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_loader import rgbw_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t byte_data,
    input  logic  byte_rdy,
    input  logic  frame_end,
    output byte_t mode,
    output byte_t lint,
    output byte_t cidx,
    output byte_t red,
    output byte_t green,
    output byte_t blue,
    output byte_t white,
    output logic  frame_valid
);

    byte_t             buf_q [FRAME_LEN];
    logic [BCNT_W-1:0] cnt;
    logic              full_frame;

    // exactly FRAME_LEN bytes seen since cs fell
    assign full_frame = (cnt == BCNT_W'(FRAME_LEN));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_end && full_frame;
            if (frame_end) begin
                cnt <= '0;
            end else if (byte_rdy && cnt <= BCNT_W'(FRAME_LEN)) begin
                // stops one past FRAME_LEN so long frames stay invalid
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // extra bytes are dropped
        if (byte_rdy && !frame_end && cnt < BCNT_W'(FRAME_LEN)) begin
            buf_q[cnt[2:0]] <= byte_data;
        end
        // fields only move on a good frame
        if (frame_end && full_frame) begin
            mode  <= buf_q[IDX_MODE];
            lint  <= buf_q[IDX_LINT];
            cidx  <= buf_q[IDX_CIDX];
            red   <= buf_q[IDX_RED];
            green <= buf_q[IDX_GREEN];
            blue  <= buf_q[IDX_BLUE];
            white <= buf_q[IDX_WHITE];
        end
    end

    // a byte landing on the frame end cycle would be lost
    a_no_byte_at_end: assert property (@(posedge clk) disable iff (!rst_n)
        frame_end |-> !byte_rdy);

endmodule

`default_nettype wire

/* hw/seq_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_mult import rgbw_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ld,
    input  byte_t a,
    input  byte_t b,
    output prod_t result,
    output logic  done
);

    logic       busy;
    logic [2:0] step;
    prod_t      a_sh;
    byte_t      b_sh;
    prod_t      acc;

    assign result = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (ld) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 3'd1;
                // eight steps, done lands on the ninth cycle after ld
                if (step == 3'd7) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // one multiplier bit per cycle, lsb first
    always_ff @(posedge clk) begin
        if (ld) begin
            a_sh <= {8'h00, a};
            b_sh <= b;
            acc  <= '0;
        end else if (busy) begin
            if (b_sh[0]) begin
                acc <= acc + a_sh;
            end
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
        end
    end

    // the scaler waits for done before the next load
    a_no_ld_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ld |-> !busy);

endmodule

`default_nettype wire

/* hw/color_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module color_scaler import rgbw_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  frame_valid,
    input  byte_t mode,
    input  byte_t lint,
    input  byte_t cidx,
    input  byte_t red,
    input  byte_t green,
    input  byte_t blue,
    input  byte_t white,
    output byte_t mul_a,
    output byte_t mul_b,
    output logic  mul_ld,
    input  prod_t mul_res,
    input  logic  mul_done,
    output byte_t duty_r,
    output byte_t duty_g,
    output byte_t duty_b,
    output byte_t duty_w
);

    scale_state_e state;
    logic [1:0]   ch;
    logic         pending;
    logic         last_store;
    logic         start;
    byte_t        mode_q;
    byte_t        lint_q;
    byte_t        cidx_q;
    byte_t        col_q [4];
    byte_t        duty_q [4];
    byte_t        sel;

    assign last_store = (state == S_STORE) && (ch == 2'd3);
    // fresh run from idle, or a queued frame right after the last channel
    assign start = ((state == S_IDLE) && frame_valid) ||
                   (last_store && (pending || frame_valid));

    // source value for the current channel
    always_comb begin
        case (mode_q)
            MODE_DIRECT:  sel = col_q[ch];
            MODE_PALETTE: sel = PALETTE[cidx_q[2:0]][ch];
            default:      sel = '0;
        endcase
    end

    assign mul_a  = sel;
    assign mul_b  = lint_q;
    assign mul_ld = (state == S_LOAD);

    // frozen copy so a later commit cannot mix into a run
    always_ff @(posedge clk) begin
        if (start) begin
            mode_q   <= mode;
            lint_q   <= lint;
            cidx_q   <= cidx;
            col_q[0] <= red;
            col_q[1] <= green;
            col_q[2] <= blue;
            col_q[3] <= white;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            ch      <= '0;
            pending <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (frame_valid) begin
                        ch    <= '0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: state <= S_WAIT;
                S_WAIT: begin
                    if (mul_done) begin
                        state <= S_STORE;
                    end
                end
                S_STORE: begin
                    if (ch != 2'd3) begin
                        ch    <= ch + 2'd1;
                        state <= S_LOAD;
                    end else if (pending || frame_valid) begin
                        ch    <= '0;
                        state <= S_LOAD;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
            // remember a frame that arrives mid run
            if (start) begin
                pending <= 1'b0;
            end else if (frame_valid && state != S_IDLE) begin
                pending <= 1'b1;
            end
        end
    end

    // high byte of source times brightness
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            duty_q <= '{default: '0};
        end else if (state == S_STORE) begin
            duty_q[ch] <= mul_res[15:8];
        end
    end

    assign duty_r = duty_q[0];
    assign duty_g = duty_q[1];
    assign duty_b = duty_q[2];
    assign duty_w = duty_q[3];

    // multiplier only finishes a product this fsm asked for
    a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> state == S_WAIT);

endmodule

`default_nettype wire

/* hw/pwm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_gen import rgbw_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  byte_t      duty_r,
    input  byte_t      duty_g,
    input  byte_t      duty_b,
    input  byte_t      duty_w,
    output logic [3:0] pwm
);

    logic [PWM_PRE_W-1:0] pre;
    logic                 tick;
    logic                 wrap;
    byte_t                cnt;
    byte_t                duty_in [4];
    byte_t                shadow [4];

    assign duty_in[0] = duty_r;
    assign duty_in[1] = duty_g;
    assign duty_in[2] = duty_b;
    assign duty_in[3] = duty_w;

    // prescaler replaces a divided clock
    assign tick = (pre == PWM_PRE_W'(PWM_DIV - 1));
    assign wrap = tick && (cnt == 8'hFF);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre    <= '0;
            cnt    <= '0;
            shadow <= '{default: '0};
            pwm    <= '0;
        end else begin
            pre <= tick ? '0 : pre + 1'b1;
            if (tick) begin
                cnt <= cnt + 8'd1;
            end
            // new duties only at period start, no partial pulses
            if (wrap) begin
                shadow <= duty_in;
            end
            // registered compare, duty 0 never goes high
            for (int i = 0; i < 4; i++) begin
                pwm[i] <= (cnt < shadow[i]);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rgbw_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module rgbw_controller import rgbw_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ena,
    input  byte_t ui_in,
    input  byte_t uio_in,
    output byte_t uo_out,
    output byte_t uio_out,
    output byte_t uio_oe
);

    byte_t      byte_data;
    logic       byte_rdy;
    logic       frame_end;
    logic       frame_valid;
    byte_t      mode;
    byte_t      lint;
    byte_t      cidx;
    byte_t      red;
    byte_t      green;
    byte_t      blue;
    byte_t      white;
    byte_t      mul_a;
    byte_t      mul_b;
    logic       mul_ld;
    prod_t      mul_res;
    logic       mul_done;
    byte_t      duty_r;
    byte_t      duty_g;
    byte_t      duty_b;
    byte_t      duty_w;
    logic [3:0] pwm;
    logic       unused_pins;

    // spare pads, no function
    assign unused_pins = &{ui_in[7:6], ui_in[2:0], uio_in, 1'b0};

    // bidir pads stay inputs
    assign uio_out = '0;
    assign uio_oe  = '0;

    // red, green, blue, white on the low pins
    assign uo_out[3:0] = pwm;
    assign uo_out[6:4] = '0;
    assign uo_out[7]   = ena;

    spi_slave u_spi (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck       (ui_in[5]),
        .cs        (ui_in[4]),
        .mosi      (ui_in[3]),
        .byte_data (byte_data),
        .byte_rdy  (byte_rdy),
        .frame_end (frame_end)
    );

    frame_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .byte_data   (byte_data),
        .byte_rdy    (byte_rdy),
        .frame_end   (frame_end),
        .mode        (mode),
        .lint        (lint),
        .cidx        (cidx),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .white       (white),
        .frame_valid (frame_valid)
    );

    color_scaler u_scaler (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .mode        (mode),
        .lint        (lint),
        .cidx        (cidx),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .white       (white),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_ld      (mul_ld),
        .mul_res     (mul_res),
        .mul_done    (mul_done),
        .duty_r      (duty_r),
        .duty_g      (duty_g),
        .duty_b      (duty_b),
        .duty_w      (duty_w)
    );

    seq_mult u_mult (
        .clk    (clk),
        .rst_n  (rst_n),
        .ld     (mul_ld),
        .a      (mul_a),
        .b      (mul_b),
        .result (mul_res),
        .done   (mul_done)
    );

    pwm_gen u_pwm (
        .clk    (clk),
        .rst_n  (rst_n),
        .duty_r (duty_r),
        .duty_g (duty_g),
        .duty_b (duty_b),
        .duty_w (duty_w),
        .pwm    (pwm)
    );

endmodule

`default_nettype wire

/* tb/tb_rgbw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rgbw import rgbw_pkg::*; ();

    // one test line: count, eight frame bytes, check mode, four duties
    localparam int COLS      = 14;
    localparam int MAX_TESTS = 32;
    localparam int COL_CHK   = 9;
    localparam int COL_DUTY  = 10;
    localparam int SCK_HALF  = 10;
    // one full pwm period in clk cycles
    localparam int PERIOD    = 256 * PWM_DIV;

    logic  clk;
    logic  rst_n;
    logic  ena;
    byte_t ui_in;
    byte_t uio_in;
    byte_t uo_out;
    byte_t uio_out;
    byte_t uio_oe;

    byte_t tv [MAX_TESTS*COLS];
    byte_t exp_duty [4];
    int    errors;
    int    checks;
    int    tests_run;
    string pin_names [4] = '{"red", "green", "blue", "white"};

    rgbw_controller dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    always #4 clk = ~clk;

    // lands 1 ns after the n-th rising edge
    task automatic step_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #1;
    endtask

    // mode 0, msb first, sck idles low
    task automatic send_byte(input byte_t b);
        for (int i = 7; i >= 0; i--) begin
            ui_in[3] = b[i];
            ui_in[5] = 1'b0;
            step_cycles(SCK_HALF);
            ui_in[5] = 1'b1;
            step_cycles(SCK_HALF);
        end
        ui_in[5] = 1'b0;
    endtask

    task automatic send_frame(input int base, input int cnt);
        ui_in[4] = 1'b0;
        for (int k = 0; k < cnt; k++) begin
            send_byte(tv[base + 1 + k]);
        end
        // cs held low past the last edge so the byte lands first
        step_cycles(SCK_HALF);
        ui_in[4] = 1'b1;
        step_cycles(4 * SCK_HALF);
    endtask

    // high time of each pin over one period, compared with duty x PWM_DIV
    task automatic check_pins(input int test_no);
        int high [4];
        high = '{default: 0};
        for (int i = 0; i < PERIOD; i++) begin
            step_cycles(1);
            for (int p = 0; p < 4; p++) begin
                if (uo_out[p]) begin
                    high[p]++;
                end
            end
        end
        for (int p = 0; p < 4; p++) begin
            checks++;
            assert (high[p] == int'(exp_duty[p]) * PWM_DIV) else begin
                errors++;
                $display("mismatch %s pin high cycles: got 0x%0h expected 0x%0h (test %0d)",
                         pin_names[p], high[p], int'(exp_duty[p]) * PWM_DIV, test_no);
            end
        end
    endtask

    // unused pads, spare outputs and the ena mirror
    task automatic check_tieoffs();
        checks += 4;
        assert (uio_out == 8'h00) else begin
            errors++;
            $display("mismatch uio_out: got 0x%02h expected 0x00", uio_out);
        end
        assert (uio_oe == 8'h00) else begin
            errors++;
            $display("mismatch uio_oe: got 0x%02h expected 0x00", uio_oe);
        end
        assert (uo_out[6:4] == 3'b000) else begin
            errors++;
            $display("mismatch uo_out[6:4]: got 0x%0h expected 0x0", uo_out[6:4]);
        end
        assert (uo_out[7] == ena) else begin
            errors++;
            $display("mismatch uo_out[7]: got 0x%0h expected 0x%0h", uo_out[7], ena);
        end
    endtask

    initial begin
        int base;
        int cnt;
        int chk;
        clk       = 1'b0;
        rst_n     = 1'b0;
        ena       = 1'b1;
        // cs idles high, sck and mosi low
        ui_in     = 8'h10;
        uio_in    = 8'h00;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        exp_duty  = '{default: 8'h00};
        $readmemh("tb/rgbw_tests.txt", tv);

        step_cycles(10);
        rst_n = 1'b1;
        step_cycles(2);

        // idle after reset: pins dark, tie-offs, ena both ways
        check_tieoffs();
        ena = 1'b0;
        step_cycles(1);
        check_tieoffs();
        ena = 1'b1;
        step_cycles(1);
        check_tieoffs();
        check_pins(0);

        for (int t = 0; t < MAX_TESTS; t++) begin
            base = t * COLS;
            cnt  = int'(tv[base]);
            // end marker
            if (cnt == 'hFF) begin
                break;
            end
            chk = int'(tv[base + COL_CHK]);
            assert (cnt >= 1 && cnt <= 8 && chk <= 2) else begin
                errors++;
                $display("test line %0d has a bad byte count or check mode", t + 1);
            end
            if (cnt < 1 || cnt > 8 || chk > 2) begin
                break;
            end
            tests_run++;
            send_frame(base, cnt);
            // chk 1 keeps the old duties, chk 2 goes straight to the next frame
            if (chk == 0) begin
                for (int p = 0; p < 4; p++) begin
                    exp_duty[p] = tv[base + COL_DUTY + p];
                end
            end
            if (chk != 2) begin
                // scaler run plus reload at wrap, with margin
                step_cycles(3 * PERIOD);
                check_pins(t + 1);
            end
        end

        check_tieoffs();
        assert (tests_run > 0) else begin
            errors++;
            $display("no test lines were read from tb/rgbw_tests.txt");
        end

        $display("tests %0d checks %0d errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rgbw_tests.txt */
// cnt, frame bytes b0..b7 (mode lint cidx r g b w, spare), chk, duties r g b w
// chk 0 compares duties, 1 keeps previous duties, 2 no check (next frame follows)
07 00 FF 00 FF 00 80 C8 00  0  FE 00 7F C7
07 00 80 00 FF 64 00 01 00  0  7F 32 00 00
07 01 FF 07 00 00 00 00 00  0  FE 7F 1F 3F
07 01 80 0F 11 22 33 44 00  0  7F 40 10 20
07 01 FF 0C 00 00 00 00 00  0  FE FE 00 00
07 01 80 0A 00 00 00 00 00  0  00 00 7F 00
07 02 FF 00 FF FF FF FF 00  0  00 00 00 00
07 00 FF 00 40 20 FF 64 00  0  3F 1F FE 63
06 00 80 00 11 22 33 00 00  1  00 00 00 00
08 00 80 00 11 22 33 44 55  1  00 00 00 00
07 FF FF 00 FF FF FF FF 00  0  00 00 00 00
07 01 FF 05 00 00 00 00 00  2  00 00 00 00
07 00 80 00 C8 80 40 20 00  0  64 40 20 10
FF

/* tb.f */
hw/rgbw_pkg.sv
hw/spi_slave.sv
hw/frame_loader.sv
hw/seq_mult.sv
hw/color_scaler.sv
hw/pwm_gen.sv
hw/rgbw_controller.sv
tb/tb_rgbw.sv

/* Makefile */
RTL_SRC := $(shell grep '^hw/' tb.f)

.PHONY: all sim lint clean

all: sim

obj_dir/Vtb_rgbw: tb.f $(RTL_SRC) tb/tb_rgbw.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rgbw -f tb.f

sim: obj_dir/Vtb_rgbw tb/rgbw_tests.txt
	./obj_dir/Vtb_rgbw > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module rgbw_controller $(RTL_SRC)

clean:
	rm -rf obj_dir sim.log
